//--- filelist.f
+incdir+.
replay_axis_pkg.sv
replay_mem_pkg.sv
buf_port_if.sv
pkt_buffer_arb.sv
pkt_loader.sv
pkt_replay_reader.sv
fifo_to_axis.sv
replay_top.sv
tb_replay_top.sv

//--- Makefile
# Verilator build for the packet replay engine

VERILATOR ?= verilator
TOP       ?= tb_replay_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_replay_top.sv
// Packet replay engine testbench
`include "replay_config.svh"

module tb_replay_top;

  localparam int word_w        = `REPLAY_DATA_W + `REPLAY_STRB_W;
  localparam int addr_w        = $clog2(`REPLAY_BUF_DEPTH);
  localparam int num_pkts      = 5;
  localparam int max_words     = 4;
  localparam int timeout_cycles = 2000;

  logic                       axi_aclk;
  logic                       axi_aresetn;
  logic                       host_req;
  logic [addr_w-1:0]          host_addr;
  logic [word_w-1:0]          host_wdata;
  logic                       host_ack;
  logic                       replay_start;
  logic [addr_w-1:0]          replay_base;
  logic [addr_w:0]            replay_words;
  logic                       replay_busy;
  logic [`REPLAY_DATA_W-1:0]  m_axis_tdata;
  logic [`REPLAY_STRB_W-1:0]  m_axis_tstrb;
  logic [`REPLAY_TUSER_W-1:0] m_axis_tuser;
  logic                       m_axis_tvalid;
  logic                       m_axis_tready;
  logic                       m_axis_tlast;

  integer seed = 39;

  // Packet table of metadata, data words and final end-mask
  logic [`REPLAY_TUSER_W-1:0] pkt_tuser [num_pkts] =
    '{16'h1a01, 16'h2b02, 16'h3c03, 16'h4d04, 16'h5e05};
  int                         pkt_len   [num_pkts] = '{3, 1, 4, 2, 2};
  logic [`REPLAY_STRB_W-1:0]  pkt_mask  [num_pkts] =
    '{4'b1000, 4'b0001, 4'b0100, 4'b0010, 4'b1000};
  logic [`REPLAY_DATA_W-1:0]  pkt_data  [num_pkts][max_words] = '{
    '{32'h11223344, 32'h55667788, 32'h99aabbcc, 32'h0},
    '{32'hdeadbeef, 32'h0,        32'h0,        32'h0},
    '{32'h0badf00d, 32'hcafe0001, 32'hcafe0002, 32'h7e57da7a},
    '{32'h01020304, 32'ha5a55a5a, 32'h0,        32'h0},
    '{32'hfeedface, 32'h13579bdf, 32'h0,        32'h0}
  };

  // Expected beats appended per replay
  logic [`REPLAY_DATA_W-1:0]  exp_data [$];
  logic [`REPLAY_STRB_W-1:0]  exp_strb [$];
  logic [`REPLAY_TUSER_W-1:0] exp_user [$];
  logic                       exp_last [$];
  int                         beat_idx = 0;

  // Beat stalled by back-pressure
  logic                       held = 1'b0;
  logic [`REPLAY_DATA_W-1:0]  held_data;
  logic [`REPLAY_STRB_W-1:0]  held_strb;
  logic [`REPLAY_TUSER_W-1:0] held_user;
  logic                       held_last;

  replay_top dut_i (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .host_req      (host_req),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .host_ack      (host_ack),
    .replay_start  (replay_start),
    .replay_base   (replay_base),
    .replay_words  (replay_words),
    .replay_busy   (replay_busy),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tstrb  (m_axis_tstrb),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #50 axi_aclk = ~axi_aclk;
  end

  // Sink accepts about three beats in four
  always @(posedge axi_aclk) begin
    m_axis_tready <= ($random(seed) & 3) != 0;
  end

  task automatic report_failure(input string reason);
    $display("ERROR: %s", reason);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      report_failure("value check failed");
    end
  endtask

  // Record word i where word 0 is the metadata
  function automatic logic [word_w-1:0] record_word(input int p, input int i);
    if (i == 0) begin
      return word_w'(pkt_tuser[p]);
    end else if (i == pkt_len[p]) begin
      return {pkt_mask[p], pkt_data[p][i-1]};
    end
    return {{`REPLAY_STRB_W{1'b0}}, pkt_data[p][i-1]};
  endfunction

  // One-hot bit k covers bytes 0 through k
  function automatic logic [`REPLAY_STRB_W-1:0] strb_for_mask(
    input logic [`REPLAY_STRB_W-1:0] mask
  );
    logic [`REPLAY_STRB_W-1:0] strb;
    int                        k;
    k = 0;
    strb = '0;
    for (int i = 0; i < `REPLAY_STRB_W; i++) begin
      if (mask[i]) k = i;
    end
    for (int i = 0; i <= k; i++) begin
      strb[i] = 1'b1;
    end
    return strb;
  endfunction

  task automatic add_beats(input int p);
    for (int i = 1; i <= pkt_len[p]; i++) begin
      exp_data.push_back(pkt_data[p][i-1]);
      exp_user.push_back(pkt_tuser[p]);
      exp_last.push_back(i == pkt_len[p]);
      exp_strb.push_back(i == pkt_len[p] ? strb_for_mask(pkt_mask[p]) : '1);
    end
  endtask

  task automatic wait_host_ack(input logic level);
    int n;
    n = 0;
    while (host_ack !== level) begin
      @(posedge axi_aclk);
      n++;
      if (n > timeout_cycles) report_failure("host_ack never reached the expected level");
    end
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (replay_busy !== level) begin
      @(posedge axi_aclk);
      n++;
      if (n > timeout_cycles) report_failure("replay_busy never reached the expected level");
    end
  endtask

  task automatic wait_beats(input int count);
    int n;
    n = 0;
    while (beat_idx < count) begin
      @(posedge axi_aclk);
      n++;
      if (n > timeout_cycles) report_failure("stream stopped before all beats arrived");
    end
  endtask

  // Full four-phase host write
  task automatic host_write(input logic [addr_w-1:0] addr, input logic [word_w-1:0] word);
    @(posedge axi_aclk);
    host_req   <= 1'b1;
    host_addr  <= addr;
    host_wdata <= word;
    @(posedge axi_aclk);
    wait_host_ack(1'b1);
    // Ack must stay up while req is high
    @(posedge axi_aclk);
    check_equal("host_ack hold", 64'(1), 64'(host_ack));
    host_req <= 1'b0;
    @(posedge axi_aclk);
    wait_host_ack(1'b0);
  endtask

  task automatic write_record(input int p, inout int addr);
    for (int i = 0; i <= pkt_len[p]; i++) begin
      host_write(addr_w'(addr), record_word(p, i));
      addr++;
    end
  endtask

  task automatic run_replay(input int base, input int words);
    @(posedge axi_aclk);
    replay_start <= 1'b1;
    replay_base  <= addr_w'(base);
    replay_words <= (addr_w + 1)'(words);
    @(posedge axi_aclk);
    replay_start <= 1'b0;
    wait_busy(1'b1);
    wait_busy(1'b0);
  endtask

  task automatic compare_beat();
    if (beat_idx >= exp_data.size()) begin
      report_failure("stream beat arrived beyond the expected list");
    end else begin
      check_equal($sformatf("beat %0d tdata", beat_idx), 64'(exp_data[beat_idx]),
                  64'(m_axis_tdata));
      check_equal($sformatf("beat %0d tuser", beat_idx), 64'(exp_user[beat_idx]),
                  64'(m_axis_tuser));
      check_equal($sformatf("beat %0d tlast", beat_idx), 64'(exp_last[beat_idx]),
                  64'(m_axis_tlast));
      check_equal($sformatf("beat %0d tstrb", beat_idx), 64'(exp_strb[beat_idx]),
                  64'(m_axis_tstrb));
      beat_idx++;
    end
  endtask

  // Stream monitor sampling values from before the edge
  always @(posedge axi_aclk) begin
    if (axi_aresetn) begin
      if (held) begin
        check_equal("tvalid under back-pressure", 64'(1), 64'(m_axis_tvalid));
        check_equal("tdata under back-pressure", 64'(held_data), 64'(m_axis_tdata));
        check_equal("tstrb under back-pressure", 64'(held_strb), 64'(m_axis_tstrb));
        check_equal("tuser under back-pressure", 64'(held_user), 64'(m_axis_tuser));
        check_equal("tlast under back-pressure", 64'(held_last), 64'(m_axis_tlast));
      end
      if (m_axis_tvalid && m_axis_tready) begin
        held = 1'b0;
        compare_beat();
      end else begin
        held      = m_axis_tvalid;
        held_data = m_axis_tdata;
        held_strb = m_axis_tstrb;
        held_user = m_axis_tuser;
        held_last = m_axis_tlast;
      end
    end
  end

  initial begin
    int addr;
    int total_words;
    int waddr;
    axi_aresetn   = 1'b0;
    host_req      = 1'b0;
    host_addr     = '0;
    host_wdata    = '0;
    replay_start  = 1'b0;
    replay_base   = '0;
    replay_words  = '0;
    m_axis_tready = 1'b0;
    repeat (5) @(posedge axi_aclk);
    axi_aresetn <= 1'b1;
    @(posedge axi_aclk);

    // Outputs idle out of reset
    check_equal("reset tvalid", 64'(0), 64'(m_axis_tvalid));
    check_equal("reset host_ack", 64'(0), 64'(host_ack));
    check_equal("reset replay_busy", 64'(0), 64'(replay_busy));

    // Whole table image from address 0
    addr = 0;
    for (int p = 0; p < num_pkts; p++) begin
      write_record(p, addr);
    end
    total_words = addr;

    // Plain replay of the full region
    for (int p = 0; p < num_pkts; p++) begin
      add_beats(p);
    end
    run_replay(0, total_words);
    wait_beats(exp_data.size());

    // Replay again while the host fills the upper region
    for (int p = 0; p < num_pkts; p++) begin
      add_beats(p);
    end
    fork
      run_replay(0, total_words);
      begin
        waddr = 48;
        write_record(1, waddr);
        write_record(3, waddr);
      end
    join
    wait_beats(exp_data.size());

    // Words written during the replay landed
    add_beats(1);
    add_beats(3);
    run_replay(48, waddr - 48);
    wait_beats(exp_data.size());

    @(posedge axi_aclk);
    check_equal("tvalid after replay", 64'(0), 64'(m_axis_tvalid));
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- replay_top.sv
// Packet replay engine top level
`include "replay_config.svh"

module replay_top import replay_mem_pkg::*, replay_axis_pkg::*; (
  input  logic                       axi_aclk,
  input  logic                       axi_aresetn,
  // Host load port
  input  logic                       host_req,
  input  buf_addr_t                  host_addr,
  input  buf_word_u                  host_wdata,
  output logic                       host_ack,
  // Replay control
  input  logic                       replay_start,
  input  buf_addr_t                  replay_base,
  input  logic [$bits(buf_addr_t):0] replay_words,
  output logic                       replay_busy,
  // Packet stream out
  output logic [`REPLAY_DATA_W-1:0]  m_axis_tdata,
  output axis_strb_t                 m_axis_tstrb,
  output axis_tuser_t                m_axis_tuser,
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output logic                       m_axis_tlast
);

  buf_port_if load_bus ();
  buf_port_if read_bus ();

  // Reader to framer FIFO
  logic      push;
  buf_word_u push_word;
  logic      fifo_full;

  pkt_buffer_arb buffer_i (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .load_port   (load_bus.arbiter),
    .read_port   (read_bus.arbiter)
  );

  pkt_loader loader_i (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .host_req    (host_req),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_ack    (host_ack),
    .buf_port    (load_bus.requester)
  );

  pkt_replay_reader reader_i (
    .axi_aclk     (axi_aclk),
    .axi_aresetn  (axi_aresetn),
    .replay_start (replay_start),
    .replay_base  (replay_base),
    .replay_words (replay_words),
    .replay_busy  (replay_busy),
    .buf_port     (read_bus.requester),
    .push         (push),
    .push_word    (push_word),
    .fifo_full    (fifo_full)
  );

  fifo_to_axis framer_i (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .push          (push),
    .push_word     (push_word),
    .fifo_full     (fifo_full),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tstrb  (m_axis_tstrb),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

//--- fifo_to_axis.sv
// Word FIFO and AXI-Stream packet framer
`include "replay_config.svh"

module fifo_to_axis import replay_mem_pkg::*, replay_axis_pkg::*; (
  input  logic                      axi_aclk,
  input  logic                      axi_aresetn,
  input  logic                      push,
  input  buf_word_u                 push_word,
  output logic                      fifo_full,
  output logic [`REPLAY_DATA_W-1:0] m_axis_tdata,
  output axis_strb_t                m_axis_tstrb,
  output axis_tuser_t               m_axis_tuser,
  output logic                      m_axis_tvalid,
  input  logic                      m_axis_tready,
  output logic                      m_axis_tlast
);

  localparam int ptr_w = $clog2(`REPLAY_FIFO_DEPTH);

  typedef enum logic {
    st_meta,
    st_data
  } frm_state_t;

  // FIFO storage and pointers
  buf_word_u      fifo_mem [`REPLAY_FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   fifo_count;
  logic             fifo_empty;
  logic             fifo_wr_en;
  logic             fifo_rd_en;
  buf_word_u        head;

  frm_state_t       state;
  axis_tuser_t      tuser_r;

  // One extra bit so mask bit k gives bytes 0..k
  logic [`REPLAY_STRB_W:0] strb_span;

  assign fifo_full  = (fifo_count == (ptr_w + 1)'(`REPLAY_FIFO_DEPTH));
  assign fifo_empty = (fifo_count == '0);
  assign fifo_wr_en = push && !fifo_full;

  // First word fall through
  assign head = fifo_mem[rd_ptr];

  always_ff @(posedge axi_aclk) begin
    if (fifo_wr_en) begin
      fifo_mem[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else begin
      if (fifo_wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo_rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({fifo_wr_en, fifo_rd_en})
        2'b10:   fifo_count <= fifo_count + 1'b1;
        2'b01:   fifo_count <= fifo_count - 1'b1;
        default: fifo_count <= fifo_count;
      endcase
    end
  end

  // Data view of the head word drives the stream
  assign m_axis_tdata = head.data.tdata;
  assign m_axis_tuser = tuser_r;
  assign m_axis_tlast = |head.data.end_mask;
  assign strb_span    = {head.data.end_mask, 1'b0} - 1'b1;
  assign m_axis_tstrb = m_axis_tlast ? strb_span[`REPLAY_STRB_W-1:0] : '1;

  always_comb begin
    fifo_rd_en    = 1'b0;
    m_axis_tvalid = 1'b0;
    case (state)
      // Metadata word is consumed without a beat
      st_meta: fifo_rd_en = !fifo_empty;
      st_data: begin
        m_axis_tvalid = !fifo_empty;
        fifo_rd_en    = !fifo_empty && m_axis_tready;
      end
      default: fifo_rd_en = 1'b0;
    endcase
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      state   <= st_meta;
      tuser_r <= '0;
    end else begin
      case (state)
        st_meta: begin
          if (!fifo_empty) begin
            tuser_r <= head.meta.tuser;
            state   <= st_data;
          end
        end
        // Back to metadata once the last beat is taken
        st_data: begin
          if (fifo_rd_en && m_axis_tlast) begin
            state <= st_meta;
          end
        end
        default: state <= st_meta;
      endcase
    end
  end

endmodule

//--- pkt_replay_reader.sv
// Buffer region reader feeding the framer FIFO

module pkt_replay_reader import replay_mem_pkg::*; (
  input  logic                    axi_aclk,
  input  logic                    axi_aresetn,
  input  logic                    replay_start,
  input  buf_addr_t               replay_base,
  input  logic [$bits(buf_addr_t):0] replay_words,
  output logic                    replay_busy,
  buf_port_if.requester           buf_port,
  output logic                    push,
  output buf_word_u               push_word,
  input  logic                    fifo_full
);

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait_ack,
    st_release
  } rd_state_t;

  rd_state_t state;
  logic      buf_req;

  // Walk position and words still to read
  buf_addr_t                   addr_r;
  logic [$bits(buf_addr_t):0]  remaining;

  assign buf_port.req   = buf_req;
  assign buf_port.we    = 1'b0;
  assign buf_port.addr  = addr_r;
  assign buf_port.wdata = '0;

  // rdata is valid while ack is high
  // a full FIFO keeps req up and stalls the push
  assign push      = (state == st_wait_ack) && buf_port.ack && !fifo_full;
  assign push_word = buf_port.rdata;

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      state       <= st_idle;
      buf_req     <= 1'b0;
      replay_busy <= 1'b0;
      addr_r      <= '0;
      remaining   <= '0;
    end else begin
      case (state)
        // Start only accepted here, so it is ignored while busy
        st_idle: begin
          if (replay_start) begin
            addr_r      <= replay_base;
            remaining   <= replay_words;
            replay_busy <= 1'b1;
            state       <= st_issue;
          end
        end
        st_issue: begin
          if (remaining == '0) begin
            replay_busy <= 1'b0;
            state       <= st_idle;
          end else if (!fifo_full) begin
            buf_req <= 1'b1;
            state   <= st_wait_ack;
          end
        end
        st_wait_ack: begin
          if (push) begin
            buf_req   <= 1'b0;
            addr_r    <= addr_r + 1'b1;
            remaining <= remaining - 1'b1;
            state     <= st_release;
          end
        end
        // One read outstanding, next one after ack falls
        st_release: begin
          if (!buf_port.ack) begin
            state <= st_issue;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

//--- pkt_loader.sv
// Host write bridge into the packet buffer

module pkt_loader import replay_mem_pkg::*; (
  input  logic              axi_aclk,
  input  logic              axi_aresetn,
  input  logic              host_req,
  input  buf_addr_t         host_addr,
  input  buf_word_u         host_wdata,
  output logic              host_ack,
  buf_port_if.requester     buf_port
);

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_hold,
    st_drain
  } ld_state_t;

  ld_state_t state;
  logic      buf_req;

  // Host command captured at request
  buf_addr_t addr_r;
  buf_word_u wdata_r;

  assign buf_port.req   = buf_req;
  assign buf_port.we    = 1'b1;
  assign buf_port.addr  = addr_r;
  assign buf_port.wdata = wdata_r;

  always_ff @(posedge axi_aclk) begin
    if (state == st_idle && host_req) begin
      addr_r  <= host_addr;
      wdata_r <= host_wdata;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      state    <= st_idle;
      buf_req  <= 1'b0;
      host_ack <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (host_req) begin
            buf_req <= 1'b1;
            state   <= st_write;
          end
        end
        // Buffer ack means the word is stored
        st_write: begin
          if (buf_port.ack) begin
            host_ack <= 1'b1;
            state    <= st_hold;
          end
        end
        // Buffer req stays up until the host lets go
        st_hold: begin
          if (!host_req) begin
            host_ack <= 1'b0;
            buf_req  <= 1'b0;
            state    <= st_drain;
          end
        end
        // Wait for the arbiter to close its side
        st_drain: begin
          if (!buf_port.ack) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

//--- pkt_buffer_arb.sv
// Packet buffer with round-robin arbiter
`include "replay_config.svh"

module pkt_buffer_arb import replay_mem_pkg::*; (
  input  logic        axi_aclk,
  input  logic        axi_aresetn,
  buf_port_if.arbiter load_port,
  buf_port_if.arbiter read_port
);

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_release
  } arb_state_t;

  arb_state_t state;

  // Port owning the current transaction, 1 for the reader
  logic       sel;
  logic       last_served;
  logic       grant_read;

  // Selected port command
  logic       sel_req;
  logic       sel_we;
  buf_addr_t  sel_addr;
  buf_word_u  sel_wdata;

  buf_word_u  mem [`REPLAY_BUF_DEPTH];
  buf_word_u  rdata_r;

  // Tie goes to the port not served last
  always_comb begin
    if (load_port.req && read_port.req) begin
      grant_read = !last_served;
    end else begin
      grant_read = read_port.req;
    end
  end

  assign sel_req   = sel ? read_port.req   : load_port.req;
  assign sel_we    = sel ? read_port.we    : load_port.we;
  assign sel_addr  = sel ? read_port.addr  : load_port.addr;
  assign sel_wdata = sel ? read_port.wdata : load_port.wdata;

  // Both ports see the last read word
  assign load_port.rdata = rdata_r;
  assign read_port.rdata = rdata_r;

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      state         <= st_idle;
      sel           <= 1'b0;
      last_served   <= 1'b1;
      load_port.ack <= 1'b0;
      read_port.ack <= 1'b0;
    end else begin
      case (state)
        // Grant in the cycle a req is seen
        st_idle: begin
          if (load_port.req || read_port.req) begin
            sel   <= grant_read;
            state <= st_access;
          end
        end
        // Access done here, ack one cycle after grant
        st_access: begin
          last_served <= sel;
          if (sel) begin
            read_port.ack <= 1'b1;
          end else begin
            load_port.ack <= 1'b1;
          end
          state <= st_release;
        end
        // Hold ack until the owner drops req
        st_release: begin
          if (!sel_req) begin
            load_port.ack <= 1'b0;
            read_port.ack <= 1'b0;
            state         <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Storage and read register
  always_ff @(posedge axi_aclk) begin
    if (state == st_access) begin
      if (sel_we) begin
        mem[sel_addr] <= sel_wdata;
      end else begin
        rdata_r <= mem[sel_addr];
      end
    end
  end

endmodule

//--- buf_port_if.sv
// Packet buffer access port

interface buf_port_if import replay_mem_pkg::*; ();

  // Four-phase handshake pair
  logic      req;
  logic      ack;

  // Access command, stable while req is high
  logic      we;
  buf_addr_t addr;
  buf_word_u wdata;

  // Read result, valid while ack is high
  buf_word_u rdata;

  modport requester (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

//--- replay_mem_pkg.sv
// Packet buffer word and address types
`include "replay_config.svh"

package replay_mem_pkg;
  import replay_axis_pkg::*;

  // Unused upper bits of a metadata word
  localparam int meta_pad_w = `REPLAY_DATA_W + `REPLAY_STRB_W - `REPLAY_TUSER_W;

  // Word address into the packet buffer
  typedef logic [$clog2(`REPLAY_BUF_DEPTH)-1:0] buf_addr_t;

  // First word of a record
  typedef struct packed {
    logic [meta_pad_w-1:0] pad;
    axis_tuser_t           tuser;
  } buf_meta_t;

  // Following words, end_mask zero until the last one
  typedef struct packed {
    axis_strb_t                end_mask;
    logic [`REPLAY_DATA_W-1:0] tdata;
  } buf_data_t;

  // Same stored word, decoded by record position
  typedef union packed {
    buf_meta_t meta;
    buf_data_t data;
  } buf_word_u;

endpackage

//--- replay_axis_pkg.sv
// Stream side types
`include "replay_config.svh"

package replay_axis_pkg;

  // Metadata held for every beat of one packet
  typedef logic [`REPLAY_TUSER_W-1:0] axis_tuser_t;

  // One bit per data byte
  typedef logic [`REPLAY_STRB_W-1:0] axis_strb_t;

endpackage

//--- replay_config.svh
// Packet replay engine configuration

`ifndef REPLAY_CONFIG_SVH
`define REPLAY_CONFIG_SVH

// Stream data bits per beat
`define REPLAY_DATA_W 32

// One end-mask bit per data byte
`define REPLAY_STRB_W 4

// Packet metadata carried on tuser
`define REPLAY_TUSER_W 16

// Packet buffer size in 36-bit words
`define REPLAY_BUF_DEPTH 64

// Framer word FIFO entries, power of two
`define REPLAY_FIFO_DEPTH 8

`endif
